// ==== Makefile ====
# Verilator flow for the MPU: lint of the RTL, simulation and clean

VERILATOR ?= verilator
FILELIST  ?= mpu_top.f
RTL_TOP   ?= mpu_top
TB_TOP    ?= tb_mpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?=

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS) $(VFLAGS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --timescale $(TIMESCALE) \
	  --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) $(VFLAGS)

# The log decides the result, whatever the simulator exit status
sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== mpu_top.f ====
verilog/mpu_pkg.sv
verilog/mpu_stage_if.sv
verilog/pma_region_lookup.sv
verilog/pma_access_check.sv
verilog/mpu_resp_fsm.sv
verilog/mpu_top.sv
sim/tb_clkgen.sv
sim/tb_mpu_top.sv

// ==== sim/tb_clkgen.sv ====
/*
  Testbench clock and reset: 4 ns clock, reset low for 3 cycles
*/
`default_nettype none

module tb_clkgen #(
  parameter int HALF_PERIOD = 2,
  parameter int RST_CYCLES  = 3
) (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the flops
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_mpu_top.sv ====
/*
  MPU testbench driving a table of core transactions against a random
  bus responder, with in-order checks of bus requests and core responses
*/
`default_nettype none

module tb_mpu_top import mpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ENTRIES    = 20;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 20;

  // Access flags {execute, atomic, misaligned, speculative}
  localparam logic [3:0] F_NONE = 4'b0000;
  localparam logic [3:0] F_EXE  = 4'b1000;
  localparam logic [3:0] F_ATO  = 4'b0100;
  localparam logic [3:0] F_MIS  = 4'b0010;
  localparam logic [3:0] F_SPE  = 4'b0001;

  typedef struct {
    addr_t       addr;
    logic        we;
    logic [3:0]  flags;
    logic        exp_bufferable;
    logic        exp_cacheable;
    mpu_status_e exp_status;
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        core_trans_valid;
  logic        core_trans_ready;
  addr_t       core_addr;
  logic        core_we;
  logic [3:0]  core_flags;
  logic        core_resp_valid;
  mpu_status_e core_resp_status;
  logic        bus_trans_valid;
  logic        bus_trans_ready;
  addr_t       bus_addr;
  logic        bus_we;
  logic        bus_bufferable;
  logic        bus_cacheable;
  logic        bus_resp_valid;

  entry_t      stim_tbl [NUM_ENTRIES];
  int          fill_idx  = 0;
  int          acc_q [$];
  int          resp_cnt  = 0;
  int          bus_ptr   = 0;
  int          hs_cnt    = 0;
  int          resp_done = 0;
  int          resp_tick = 0;
  int          req_tick [NUM_ENTRIES];
  int          cycle_cnt = 0;
  int          seed      = 75529;

  tb_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mpu_top u_mpu_top (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid),
    .core_trans_ready_o (core_trans_ready),
    .core_addr_i        (core_addr),
    .core_we_i          (core_we),
    .core_execute_i     (core_flags[3]),
    .core_atomic_i      (core_flags[2]),
    .core_misaligned_i  (core_flags[1]),
    .core_speculative_i (core_flags[0]),
    .core_resp_valid_o  (core_resp_valid),
    .core_resp_status_o (core_resp_status),
    .bus_trans_valid_o  (bus_trans_valid),
    .bus_trans_ready_i  (bus_trans_ready),
    .bus_addr_o         (bus_addr),
    .bus_we_o           (bus_we),
    .bus_bufferable_o   (bus_bufferable),
    .bus_cacheable_o    (bus_cacheable),
    .bus_resp_valid_i   (bus_resp_valid)
  );

  //////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_status(input mpu_status_e got, input mpu_status_e exp,
                              input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  task automatic add_entry(input addr_t addr, input logic we, input logic [3:0] flags,
                           input logic bufferable, input logic cacheable,
                           input mpu_status_e status);
    stim_tbl[fill_idx].addr           = addr;
    stim_tbl[fill_idx].we             = we;
    stim_tbl[fill_idx].flags          = flags;
    stim_tbl[fill_idx].exp_bufferable = bufferable;
    stim_tbl[fill_idx].exp_cacheable  = cacheable;
    stim_tbl[fill_idx].exp_status     = status;
    fill_idx++;
  endtask

  task automatic load_table();
    add_entry(32'h0000_0100, 1'b0, F_NONE, 1'b1, 1'b1, MPU_OK);
    // Region 1 shadows region 3 here
    add_entry(32'h1000_0900, 1'b0, F_NONE, 1'b1, 1'b0, MPU_OK);
    add_entry(32'h1000_0ffc, 1'b1, F_NONE, 1'b1, 1'b0, MPU_OK);
    add_entry(32'h1000_1800, 1'b0, F_NONE, 1'b0, 1'b1, MPU_OK);
    // No region matches
    add_entry(32'h3000_0000, 1'b0, F_NONE, 1'b0, 1'b0, MPU_OK);
    add_entry(32'h3000_0000, 1'b0, F_EXE,  1'b0, 1'b0, MPU_RE_FAULT);
    // Fault rule cases
    add_entry(32'h1000_0100, 1'b1, F_ATO,  1'b0, 1'b0, MPU_WR_FAULT);
    add_entry(32'h2000_0010, 1'b0, F_MIS,  1'b0, 1'b0, MPU_RE_FAULT);
    add_entry(32'h2000_0020, 1'b1, F_SPE,  1'b0, 1'b0, MPU_WR_FAULT);
    add_entry(32'h2000_0030, 1'b0, F_ATO,  1'b0, 1'b0, MPU_RE_FAULT);
    // Same flags on main and atomic regions
    add_entry(32'h0000_0200, 1'b1, F_ATO,  1'b1, 1'b1, MPU_OK);
    add_entry(32'h1000_1000, 1'b0, F_MIS,  1'b0, 1'b1, MPU_OK);
    add_entry(32'h1000_0400, 1'b0, F_SPE,  1'b1, 1'b0, MPU_OK);
    add_entry(32'h1000_1804, 1'b1, F_ATO,  1'b0, 1'b1, MPU_OK);
    add_entry(32'h2000_0100, 1'b1, F_NONE, 1'b0, 1'b0, MPU_OK);
    // Error right behind a burst of allowed accesses
    add_entry(32'h0000_0300, 1'b0, F_NONE, 1'b1, 1'b1, MPU_OK);
    add_entry(32'h0000_0304, 1'b1, F_NONE, 1'b1, 1'b1, MPU_OK);
    add_entry(32'h0000_fffc, 1'b0, F_NONE, 1'b1, 1'b1, MPU_OK);
    add_entry(32'h2000_0000, 1'b0, F_EXE,  1'b0, 1'b0, MPU_RE_FAULT);
    add_entry(32'h0001_0000, 1'b1, F_NONE, 1'b0, 1'b0, MPU_OK);
  endtask

  function automatic int next_allowed(input int from);
    int k;
    k = from;
    while (k < NUM_ENTRIES && stim_tbl[k].exp_status != MPU_OK) begin
      k++;
    end
    return k;
  endfunction

  task automatic apply_entry(input int idx);
    @(negedge clk);
    core_trans_valid = 1'b1;
    core_addr        = stim_tbl[idx].addr;
    core_we          = stim_tbl[idx].we;
    core_flags       = stim_tbl[idx].flags;
    do begin
      @(posedge clk);
    end while (!core_trans_ready);
    acc_q.push_back(idx);
  endtask

  initial begin : stimulus
    core_trans_valid = 1'b0;
    core_addr        = '0;
    core_we          = 1'b0;
    core_flags       = F_NONE;
    load_table();
    wait (rst_n === 1'b1);
    // Empty pipeline out of reset
    check_flag(core_trans_ready, 1'b1, "core ready after reset");
    check_flag(bus_trans_valid, 1'b0, "bus request valid after reset");
    check_flag(core_resp_valid, 1'b0, "core response valid after reset");
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_entry(i);
    end
    @(negedge clk);
    core_trans_valid = 1'b0;
    while (resp_cnt < NUM_ENTRIES) begin
      @(posedge clk);
    end
    // A few idle cycles to catch stray requests or responses
    repeat (8) @(posedge clk);
    check_flag(next_allowed(bus_ptr) == NUM_ENTRIES, 1'b1, "all allowed entries on bus");
    check_flag(core_trans_ready, 1'b1, "core ready after drain");
    check_flag(bus_trans_valid, 1'b0, "bus request valid after drain");
    $display("ALL TESTS PASSED");
    $finish;
  end

  //////////////////////////////
  // Bus responder
  //////////////////////////////

  // In-order responses 1 to 3 cycles after each request
  initial begin : responder
    int   cur_due;
    logic have_due;
    cur_due         = 0;
    have_due        = 1'b0;
    bus_trans_ready = 1'b0;
    bus_resp_valid  = 1'b0;
    forever begin
      @(negedge clk);
      resp_tick++;
      bus_trans_ready = (($random(seed) % 4) != 0);
      bus_resp_valid  = 1'b0;
      if (!have_due && resp_done < hs_cnt) begin
        cur_due  = req_tick[resp_done] + 1 + int'($unsigned($random(seed)) % 3);
        have_due = 1'b1;
      end
      if (have_due && cur_due <= resp_tick) begin
        bus_resp_valid = 1'b1;
        resp_done++;
        have_due = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Monitors and timeout
  //////////////////////////////

  always @(posedge clk) begin : monitor
    int idx;
    if (core_resp_valid) begin
      if (resp_cnt >= acc_q.size()) begin
        abort_run("Core response seen with no accepted transaction waiting for it");
      end else begin
        idx = acc_q[resp_cnt];
        check_status(core_resp_status, stim_tbl[idx].exp_status,
                     $sformatf("status of entry %0d", idx));
        if (stim_tbl[idx].exp_status != MPU_OK) begin
          check_flag(bus_resp_valid, 1'b0, "bus response in error response cycle");
          check_flag(resp_done == hs_cnt, 1'b1,
                     $sformatf("earlier bus responses done before entry %0d", idx));
        end
        resp_cnt++;
      end
    end
    if (bus_trans_valid && bus_trans_ready) begin
      idx = next_allowed(bus_ptr);
      if (idx >= acc_q.size()) begin
        abort_run("Bus request seen with no allowed transaction accepted for it");
      end else begin
        check_addr(bus_addr, stim_tbl[idx].addr, $sformatf("bus address of entry %0d", idx));
        check_flag(bus_we, stim_tbl[idx].we, $sformatf("bus we of entry %0d", idx));
        check_flag(bus_bufferable, stim_tbl[idx].exp_bufferable,
                   $sformatf("bufferable of entry %0d", idx));
        check_flag(bus_cacheable, stim_tbl[idx].exp_cacheable,
                   $sformatf("cacheable of entry %0d", idx));
        req_tick[hs_cnt] = resp_tick;
        hs_cnt++;
        bus_ptr = idx + 1;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout after %0d cycles with %0d of %0d responses received",
                          cycle_cnt, resp_cnt, NUM_ENTRIES));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mpu_pkg.sv ====
/*
  MPU package: address and status types, PMA region record,
  the fixed region table and the outstanding-response limit
*/
`default_nettype none

package mpu_pkg;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  typedef logic [31:0] addr_t;
  typedef logic [29:0] word_addr_t;

  // Region bounds are word addresses, low inclusive and high exclusive
  typedef struct packed {
    word_addr_t word_addr_low;
    word_addr_t word_addr_high;
    logic       main;
    logic       bufferable;
    logic       cacheable;
    logic       atomic;
  } pma_region_t;

  //////////////////////////////
  // Region table
  //////////////////////////////

  localparam int PMA_NUM_REGIONS = 4;

  // Index 0 wins when regions overlap
  localparam pma_region_t PMA_CFG [PMA_NUM_REGIONS] = '{
    // Main memory 0x0000_0000 - 0x0000_ffff
    '{word_addr_low: 30'h0000_0000, word_addr_high: 30'h0000_4000,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b1, atomic: 1'b1},
    // Main memory 0x1000_0000 - 0x1000_0fff, bufferable only
    '{word_addr_low: 30'h0400_0000, word_addr_high: 30'h0400_0400,
      main: 1'b1, bufferable: 1'b1, cacheable: 1'b0, atomic: 1'b0},
    // Peripheral I/O 0x2000_0000 - 0x2000_0fff
    '{word_addr_low: 30'h0800_0000, word_addr_high: 30'h0800_0400,
      main: 1'b0, bufferable: 1'b0, cacheable: 1'b0, atomic: 1'b0},
    // Main memory 0x1000_0800 - 0x1000_1fff, partly shadowed by region 1
    '{word_addr_low: 30'h0400_0200, word_addr_high: 30'h0400_0800,
      main: 1'b1, bufferable: 1'b0, cacheable: 1'b1, atomic: 1'b1}
  };

  // No match: treated as I/O without atomics
  localparam pma_region_t PMA_R_NOMATCH = '{default: '0};

  //////////////////////////////
  // Status and control
  //////////////////////////////

  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  typedef enum logic [1:0] {
    MPU_IDLE     = 2'b00,
    MPU_ERR_WAIT = 2'b01,
    MPU_ERR_RESP = 2'b10
  } mpu_state_e;

  // Bus transactions still waiting for a response
  localparam int MAX_OUTSTANDING = 3;

  typedef logic [1:0] outst_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/mpu_resp_fsm.sv ====
/*
  MPU stage 3: forwards allowed transactions to the bus, tracks
  outstanding responses and sequences in-order error responses
*/
`default_nettype none

module mpu_resp_fsm import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  mpu_stage_if.sink   in_if,
  output logic        bus_trans_valid_o,
  input  logic        bus_trans_ready_i,
  output addr_t       bus_addr_o,
  output logic        bus_we_o,
  output logic        bus_bufferable_o,
  output logic        bus_cacheable_o,
  input  logic        bus_resp_valid_i,
  output logic        core_resp_valid_o,
  output mpu_status_e core_resp_status_o
);

  mpu_state_e state_q;
  mpu_state_e state_d;
  outst_cnt_t cnt_q;
  outst_cnt_t cnt_d;
  logic       cnt_full;
  logic       idle;
  logic       bus_hs;
  logic       err_resp;

  assign idle     = (state_q == MPU_IDLE);
  assign err_resp = (state_q == MPU_ERR_RESP);
  assign cnt_full = (cnt_q == outst_cnt_t'(MAX_OUTSTANDING));

  //////////////////////////////
  // Bus request side
  //////////////////////////////

  // Faulting items are never presented to the bus
  assign bus_trans_valid_o = in_if.valid && !in_if.err && idle && !cnt_full;
  assign bus_addr_o        = in_if.addr;
  assign bus_we_o          = in_if.we;
  assign bus_bufferable_o  = in_if.cfg.bufferable;
  assign bus_cacheable_o   = in_if.cfg.cacheable;
  assign bus_hs            = bus_trans_valid_o && bus_trans_ready_i;

  // Allowed items leave on the bus handshake, error items on their response
  assign in_if.ready = err_resp ||
                       (idle && !in_if.err && !cnt_full && bus_trans_ready_i);

  always_comb begin
    cnt_d = cnt_q;
    case ({bus_hs, bus_resp_valid_i})
      2'b10:   cnt_d = cnt_q + outst_cnt_t'(1);
      2'b01:   cnt_d = cnt_q - outst_cnt_t'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  //////////////////////////////
  // Error sequencing
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (in_if.valid && in_if.err) begin
          state_d = MPU_ERR_WAIT;
        end
      end
      // Earlier bus responses must drain first
      MPU_ERR_WAIT: begin
        if (cnt_q == '0) begin
          state_d = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: state_d = MPU_IDLE;
      default:      state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Counter is zero during ERR_RESP, so no bus response can collide
  assign core_resp_valid_o = bus_resp_valid_i || err_resp;

  always_comb begin
    core_resp_status_o = MPU_OK;
    if (err_resp) begin
      core_resp_status_o = in_if.we ? MPU_WR_FAULT : MPU_RE_FAULT;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mpu_stage_if.sv ====
/*
  MPU pipeline stage link: one transaction with its region record
*/
`default_nettype none

interface mpu_stage_if import mpu_pkg::*; ();

  logic        valid;
  logic        ready;
  addr_t       addr;
  logic        we;
  // Access flags from the core
  logic        execute;
  logic        atomic;
  logic        misaligned;
  logic        speculative;
  pma_region_t cfg;
  logic        err;

  modport source (
    output valid, addr, we, execute, atomic, misaligned, speculative, cfg, err,
    input  ready
  );

  modport sink (
    input  valid, addr, we, execute, atomic, misaligned, speculative, cfg, err,
    output ready
  );

endinterface

`default_nettype wire

// ==== verilog/mpu_top.sv ====
/*
  MPU top: region lookup, access check and response stages
  between the core transaction port and the bus master port
*/
`default_nettype none

module mpu_top import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Core side
  input  logic        core_trans_valid_i,
  output logic        core_trans_ready_o,
  input  addr_t       core_addr_i,
  input  logic        core_we_i,
  input  logic        core_execute_i,
  input  logic        core_atomic_i,
  input  logic        core_misaligned_i,
  input  logic        core_speculative_i,
  output logic        core_resp_valid_o,
  output mpu_status_e core_resp_status_o,

  // Bus side
  output logic        bus_trans_valid_o,
  input  logic        bus_trans_ready_i,
  output addr_t       bus_addr_o,
  output logic        bus_we_o,
  output logic        bus_bufferable_o,
  output logic        bus_cacheable_o,
  input  logic        bus_resp_valid_i
);

  mpu_stage_if s1_if ();
  mpu_stage_if s2_if ();

  pma_region_lookup u_lookup (
    .clk                (clk),
    .rst_n              (rst_n),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_addr_i        (core_addr_i),
    .core_we_i          (core_we_i),
    .core_execute_i     (core_execute_i),
    .core_atomic_i      (core_atomic_i),
    .core_misaligned_i  (core_misaligned_i),
    .core_speculative_i (core_speculative_i),
    .out_if             (s1_if.source)
  );

  pma_access_check u_check (
    .clk    (clk),
    .rst_n  (rst_n),
    .in_if  (s1_if.sink),
    .out_if (s2_if.source)
  );

  mpu_resp_fsm u_resp (
    .clk                (clk),
    .rst_n              (rst_n),
    .in_if              (s2_if.sink),
    .bus_trans_valid_o  (bus_trans_valid_o),
    .bus_trans_ready_i  (bus_trans_ready_i),
    .bus_addr_o         (bus_addr_o),
    .bus_we_o           (bus_we_o),
    .bus_bufferable_o   (bus_bufferable_o),
    .bus_cacheable_o    (bus_cacheable_o),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_status_o (core_resp_status_o)
  );

endmodule

`default_nettype wire

// ==== verilog/pma_access_check.sv ====
/*
  MPU stage 2: applies the PMA access rule and registers the
  transaction together with its error flag
*/
`default_nettype none

module pma_access_check import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  mpu_stage_if.sink   in_if,
  mpu_stage_if.source out_if
);

  logic        rule_err;
  logic        accept;

  logic        slot_valid_q;
  addr_t       addr_q;
  logic        we_q;
  logic        execute_q;
  logic        atomic_q;
  logic        misaligned_q;
  logic        speculative_q;
  pma_region_t cfg_q;
  logic        err_q;

  // Execute, speculative and misaligned need main memory
  // Atomics need an atomic region
  assign rule_err = ((in_if.execute || in_if.speculative || in_if.misaligned) &&
                     !in_if.cfg.main) ||
                    (in_if.atomic && !in_if.cfg.atomic);

  assign in_if.ready = !slot_valid_q || out_if.ready;
  assign accept      = in_if.valid && in_if.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= 1'b0;
    end else if (in_if.ready) begin
      slot_valid_q <= in_if.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q        <= in_if.addr;
      we_q          <= in_if.we;
      execute_q     <= in_if.execute;
      atomic_q      <= in_if.atomic;
      misaligned_q  <= in_if.misaligned;
      speculative_q <= in_if.speculative;
      cfg_q         <= in_if.cfg;
      err_q         <= rule_err;
    end
  end

  assign out_if.valid       = slot_valid_q;
  assign out_if.addr        = addr_q;
  assign out_if.we          = we_q;
  assign out_if.execute     = execute_q;
  assign out_if.atomic      = atomic_q;
  assign out_if.misaligned  = misaligned_q;
  assign out_if.speculative = speculative_q;
  assign out_if.cfg         = cfg_q;
  assign out_if.err         = err_q;

endmodule

`default_nettype wire

// ==== verilog/pma_region_lookup.sv ====
/*
  MPU stage 1: finds the lowest matching PMA region for a core
  transaction and registers both in a single slot
*/
`default_nettype none

module pma_region_lookup import mpu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        core_trans_valid_i,
  output logic        core_trans_ready_o,
  input  addr_t       core_addr_i,
  input  logic        core_we_i,
  input  logic        core_execute_i,
  input  logic        core_atomic_i,
  input  logic        core_misaligned_i,
  input  logic        core_speculative_i,
  mpu_stage_if.source out_if
);

  logic        match_found;
  pma_region_t match_cfg;
  logic        accept;

  logic        slot_valid_q;
  addr_t       addr_q;
  logic        we_q;
  logic        execute_q;
  logic        atomic_q;
  logic        misaligned_q;
  logic        speculative_q;
  pma_region_t cfg_q;

  //////////////////////////////
  // Region match
  //////////////////////////////

  // First hit from index 0 upward, bounds scaled to bytes
  always_comb begin
    match_found = 1'b0;
    match_cfg   = PMA_R_NOMATCH;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      if (!match_found &&
          (core_addr_i >= {PMA_CFG[i].word_addr_low, 2'b00}) &&
          (core_addr_i <  {PMA_CFG[i].word_addr_high, 2'b00})) begin
        match_found = 1'b1;
        match_cfg   = PMA_CFG[i];
      end
    end
  end

  //////////////////////////////
  // Slot
  //////////////////////////////

  // Free slot, or the current item leaves this cycle
  assign core_trans_ready_o = !slot_valid_q || out_if.ready;
  assign accept             = core_trans_valid_i && core_trans_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= 1'b0;
    end else if (core_trans_ready_o) begin
      slot_valid_q <= core_trans_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q        <= core_addr_i;
      we_q          <= core_we_i;
      execute_q     <= core_execute_i;
      atomic_q      <= core_atomic_i;
      misaligned_q  <= core_misaligned_i;
      speculative_q <= core_speculative_i;
      cfg_q         <= match_cfg;
    end
  end

  assign out_if.valid       = slot_valid_q;
  assign out_if.addr        = addr_q;
  assign out_if.we          = we_q;
  assign out_if.execute     = execute_q;
  assign out_if.atomic      = atomic_q;
  assign out_if.misaligned  = misaligned_q;
  assign out_if.speculative = speculative_q;
  assign out_if.cfg         = cfg_q;
  // Rule not evaluated yet
  assign out_if.err         = 1'b0;

endmodule

`default_nettype wire
